/* files.f */
+incdir+verilog
verilog/rv32_ctrl_pkg.sv
verilog/ctrl_ifs.sv
verilog/inst_decoder.sv
verilog/fetch_ctrl.sv
verilog/dx_ctrl.sv
verilog/wb_ctrl.sv
verilog/hazard_unit.sv
verilog/rv32_ctrl.sv
test/rv32_ctrl_asserts.sv
test/tb_rv32_ctrl.sv

/* test/rv32_ctrl_asserts.sv */
module rv32_ctrl_asserts (
   input logic clk,
   input logic reset,
   input logic stall_dx,
   input logic kill_dx,
   input logic stall_wb,
   input logic dmem_en,
   input logic retire_wb,
   input logic exception_wb,
   input logic wr_reg_wb
);

   // a held DX instruction leaves a bubble in WB
   assert property (@(posedge clk) disable iff (reset) (stall_dx && !stall_wb) |=> !retire_wb)
      else $error("stalled DX instruction retired in WB");

   // killed DX instruction must not reach WB as a write or memory access
   assert property (@(posedge clk) disable iff (reset)
                    (kill_dx && !stall_wb) |=> !(wr_reg_wb || stall_wb))
      else $error("killed DX instruction acted in WB");

   assert property (@(posedge clk) disable iff (reset) exception_wb |=> !retire_wb)
      else $error("instruction after a WB exception retired");

   // first cycle out of reset is a bubble
   assert property (@(posedge clk) $fell(reset) |-> !wr_reg_wb)
      else $error("wr_reg_wb high right after reset");

endmodule

bind rv32_ctrl rv32_ctrl_asserts asserts0 (
   .clk(clk), .reset(reset), .stall_dx(stall_dx), .kill_dx(kill_dx), .stall_wb(stall_wb),
   .dmem_en(dmem_en), .retire_wb(retire_wb), .exception_wb(exception_wb),
   .wr_reg_wb(wr_reg_wb)
);

/* test/rv32_ctrl_testdata.txt */
# inputs: inst_dx imem_wait imem_badmem_e dmem_wait dmem_badmem_e cmp_true misaligned_addr_p misaligned_fetch
# expected: pc_src_sel alu_op src_a src_b imm stall_if kill_if stall_dx byp_rs1 dmem_en wr_reg_wb rd_wb exc_wb code_wb retire_wb
00000013 0 0 0 0 0 0 0  4 0 0 1 0 0 1 0 0 0 0 0 0 1 0
00000013 0 0 0 0 0 0 0  0 0 0 1 0 0 0 0 0 0 1 0 0 1 0
002082b3 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0 1 0 0 1 0
40328333 0 0 0 0 0 0 0  0 a 0 0 0 0 0 0 1 0 1 5 0 1 1
4020d3b3 0 0 0 0 0 0 0  0 b 0 0 0 0 0 0 0 0 1 6 0 1 1
0020b433 0 0 0 0 0 0 0  0 e 0 0 0 0 0 0 0 0 1 7 0 1 1
123454b7 0 0 0 0 0 0 0  0 0 2 1 2 0 0 0 0 0 1 8 0 1 1
00001517 0 0 0 0 0 0 0  0 0 1 1 2 0 0 0 0 0 1 9 0 1 1
00208463 0 0 0 0 0 0 0  1 8 0 0 0 0 0 0 0 0 1 a 0 1 1
00209463 0 0 0 0 0 0 0  1 9 0 0 0 0 0 0 0 0 0 8 0 1 1
0020c463 0 0 0 0 0 0 0  1 c 0 0 0 0 0 0 0 0 0 8 0 1 1
0020d463 0 0 0 0 0 0 0  1 d 0 0 0 0 0 0 0 0 0 8 0 1 1
0020e463 0 0 0 0 0 0 0  1 e 0 0 0 0 0 0 0 0 0 8 0 1 1
0020f463 0 0 0 0 1 0 0  1 f 0 0 0 0 1 0 0 0 0 8 0 1 1
00000013 0 0 0 0 0 0 0  0 0 0 1 0 0 0 0 0 0 0 8 0 1 1
010000ef 0 0 0 0 0 0 0  2 0 1 2 0 0 1 0 0 0 1 0 0 1 0
00000013 0 0 0 0 0 0 0  0 0 0 1 0 0 0 0 0 0 1 1 0 1 1
00000013 0 0 0 0 0 0 0  0 0 0 1 0 0 0 0 0 0 1 0 0 1 0
0000a283 0 0 0 0 0 0 0  0 0 0 1 0 0 0 0 0 1 1 0 0 1 1
40328333 0 0 0 0 0 0 0  4 a 0 0 0 1 1 1 0 0 1 5 0 1 1
40328333 0 0 0 0 0 0 0  0 a 0 0 0 0 0 0 0 0 0 6 0 1 0
0000a283 0 0 0 0 0 0 0  0 0 0 1 0 0 0 0 0 1 1 6 0 1 1
00000013 0 0 1 0 0 0 0  4 0 0 1 0 1 1 1 0 0 0 5 0 1 0
00000013 0 0 1 0 0 0 0  4 0 0 1 0 1 1 1 0 0 0 5 0 1 0
00000013 0 0 0 0 0 0 0  0 0 0 1 0 0 0 0 0 0 1 5 0 1 1
00000000 0 0 0 0 0 0 0  0 0 0 1 0 0 1 0 0 0 1 0 0 1 1
00000013 0 0 0 0 0 0 0  5 0 0 1 0 0 1 0 0 0 0 0 1 2 0
00000013 0 0 0 0 0 0 0  0 0 0 1 0 0 0 0 0 0 0 0 0 1 0
00100073 0 0 0 0 0 0 0  0 0 0 1 0 0 1 0 0 0 1 0 0 1 0
00000013 0 0 0 0 0 0 0  5 0 0 1 0 0 1 0 0 0 0 0 1 3 0
00000013 0 0 0 0 0 0 0  0 0 0 1 0 0 0 0 0 0 0 0 0 1 0
00000013 0 0 0 0 0 0 0  0 0 0 1 0 0 0 0 0 0 1 0 0 1 0
0020a023 0 0 0 0 0 1 0  0 0 0 1 1 0 1 0 0 0 1 0 0 1 1
00000013 0 0 0 0 0 0 0  5 0 0 1 0 0 1 0 0 0 0 0 1 6 0
00000013 0 0 0 0 0 0 0  0 0 0 1 0 0 0 0 0 0 0 0 0 1 0
00000013 0 0 0 0 0 0 0  0 0 0 1 0 0 0 0 0 0 1 0 0 1 0
0000a283 0 0 0 0 0 0 0  0 0 0 1 0 0 0 0 0 1 1 0 0 1 1
00000013 0 0 0 1 0 0 0  5 0 0 1 0 0 1 0 0 0 0 5 1 5 0
00000013 0 0 0 0 0 0 0  0 0 0 1 0 0 0 0 0 0 0 0 0 1 0
00000013 0 0 0 0 0 0 0  0 0 0 1 0 0 0 0 0 0 1 0 0 1 0

/* test/tb_rv32_ctrl.sv */
`include "rv32_ctrl_defines.svh"

module tb_rv32_ctrl;
   import rv32_ctrl_pkg::*;

   localparam int MAX_VECS = 256;
   localparam int NUM_FIELDS = 23;  // 8 inputs then 15 expected outputs

   logic clk;
   logic reset;
   logic [`CTRL_INST_WIDTH-1:0] inst_dx;
   logic imem_wait;
   logic imem_badmem_e;
   logic dmem_wait;
   logic dmem_badmem_e;
   logic cmp_true;
   logic misaligned_addr_p;
   logic misaligned_fetch;

   pc_src_sel_e pc_src_sel;
   logic branch_taken;
   imm_type_e imm_type;
   logic bypass_rs1;
   logic bypass_rs2;
   src_a_sel_e src_a_sel;
   src_b_sel_e src_b_sel;
   alu_op_e alu_op;
   logic dmem_en;
   logic dmem_wen;
   logic [2:0] dmem_size;
   logic [`CTRL_MEM_TYPE_WIDTH-1:0] dmem_type;
   logic wr_reg_wb;
   logic [`CTRL_REG_ADDR_WIDTH-1:0] reg_to_wr_wb;
   wb_src_sel_e wb_src_sel_wb;
   logic stall_if;
   logic kill_if;
   logic stall_dx;
   logic kill_dx;
   logic stall_wb;
   logic kill_wb;
   logic exception_wb;
   ecode_e exception_code_wb;
   logic retire_wb;

   logic [31:0] vec [0:MAX_VECS-1][0:NUM_FIELDS-1];
   int num_vecs = 0;
   int cur_vec = 0;
   int cycle_count = 0;
   int cycle_limit = 0;  // 0 until the vectors are loaded
   wb_src_sel_e exp_wb_src = WB_SRC_ALU;  // reset bubble is an addi

   rv32_ctrl dut0 (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
         $display("simulation did not finish within %0d cycles", cycle_limit);
         $display("Test failed");
         $fatal(1, "timeout");
      end
   end

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         $display("Error at time %0t: vector %0d, %s is %0h, expected %0h",
                  $time, cur_vec, name, actual, expected);
         $display("Test failed");
         $fatal(1, "output mismatch");
      end
   endtask

   task automatic load_vectors();
      int fd;
      int n;
      int k;
      string line;
      logic [31:0] f [0:NUM_FIELDS-1];
      fd = $fopen("test/rv32_ctrl_testdata.txt", "r");
      if (fd == 0) begin
         $display("cannot open test/rv32_ctrl_testdata.txt");
         $display("Test failed");
         $fatal(1, "missing test data");
      end
      while (!$feof(fd) && num_vecs < MAX_VECS) begin
         line = "";
         n = $fgets(line, fd);
         if (n > 0 && line[0] != "#") begin  // '#' marks a comment line
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                        f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19],
                        f[20], f[21], f[22]);
            if (n == NUM_FIELDS) begin
               for (k = 0; k < NUM_FIELDS; k++)
                  vec[num_vecs][k] = f[k];
               num_vecs++;
            end else if (n > 0) begin
               $display("malformed line in test data: %s", line);
               $display("Test failed");
               $fatal(1, "bad test data");
            end
         end
      end
      $fclose(fd);
   endtask

   task automatic drive_vector(input int i);
      inst_dx = vec[i][0];
      imem_wait = vec[i][1][0];
      imem_badmem_e = vec[i][2][0];
      dmem_wait = vec[i][3][0];
      dmem_badmem_e = vec[i][4][0];
      cmp_true = vec[i][5][0];
      misaligned_addr_p = vec[i][6][0];
      misaligned_fetch = vec[i][7][0];
   endtask

   task automatic check_vector(input int i);
      logic [6:0] opc;
      logic [4:0] rs2;
      logic exp_stall_wb;
      logic exp_ex_dx;
      logic exp_byp_rs2;
      opc = vec[i][0][6:0];
      rs2 = vec[i][0][24:20];
      exp_stall_wb = vec[i][3][0] && vec[i][15][0];  // memory wait holds WB
      // a DX fault shows up in WB on the next vector, unless it is a bus fault there
      exp_ex_dx = (i + 1 < num_vecs) && vec[i+1][20][0] && !vec[i+1][4][0] && !exp_stall_wb;
      exp_byp_rs2 = vec[i][18][0] && !vec[i][15][0] && rs2 != 0 &&
                    rs2 == vec[i][19][4:0] &&
                    (opc == OPC_OP || opc == OPC_STORE || opc == OPC_BRANCH);
      check_value("pc_src_sel", pc_src_sel, vec[i][8]);
      check_value("alu_op", alu_op, vec[i][9]);
      check_value("src_a_sel", src_a_sel, vec[i][10]);
      check_value("src_b_sel", src_b_sel, vec[i][11]);
      check_value("imm_type", imm_type, vec[i][12]);
      check_value("stall_if", stall_if, vec[i][13]);
      check_value("kill_if", kill_if, vec[i][14]);
      check_value("stall_dx", stall_dx, vec[i][15]);
      check_value("bypass_rs1", bypass_rs1, vec[i][16]);
      check_value("dmem_en", dmem_en, vec[i][17]);
      check_value("wr_reg_wb", wr_reg_wb, vec[i][18]);
      check_value("reg_to_wr_wb", reg_to_wr_wb, vec[i][19]);
      check_value("exception_wb", exception_wb, vec[i][20]);
      check_value("exception_code_wb", exception_code_wb, vec[i][21]);
      check_value("retire_wb", retire_wb, vec[i][22]);
      check_value("branch_taken", branch_taken,
                  vec[i][5][0] && vec[i][8] == PC_BRANCH_TARGET);
      check_value("bypass_rs2", bypass_rs2, exp_byp_rs2);
      check_value("dmem_wen", dmem_wen, vec[i][17][0] && opc == OPC_STORE);
      if (opc == OPC_LOAD || opc == OPC_STORE) begin
         check_value("dmem_size", dmem_size, vec[i][0][13:12]);
         check_value("dmem_type", dmem_type, vec[i][0][14:12]);
      end
      check_value("wb_src_sel_wb", wb_src_sel_wb, exp_wb_src);
      check_value("stall_wb", stall_wb, exp_stall_wb);
      check_value("kill_wb", kill_wb, exp_stall_wb || vec[i][20][0]);
      check_value("kill_dx", kill_dx, vec[i][15][0] || vec[i][20][0] || exp_ex_dx);
      if (!exp_stall_wb)
         exp_wb_src = (opc == OPC_LOAD) ? WB_SRC_MEM : WB_SRC_ALU;
   endtask

   initial begin
      int i;
      reset = 1'b1;
      inst_dx = 32'h0000_0013;  // addi x0, x0, 0
      imem_wait = 1'b0;
      imem_badmem_e = 1'b0;
      dmem_wait = 1'b0;
      dmem_badmem_e = 1'b0;
      cmp_true = 1'b0;
      misaligned_addr_p = 1'b0;
      misaligned_fetch = 1'b0;
      load_vectors();
      if (num_vecs == 0) begin
         $display("no vectors found in test data");
         $display("Test failed");
         $fatal(1, "empty test data");
      end
      cycle_limit = 2 * num_vecs + 20;
      repeat (8) @(posedge clk);
      #10;
      reset = 1'b0;
      for (i = 0; i < num_vecs; i++) begin
         cur_vec = i;
         drive_vector(i);
         #80;  // just before the next edge
         check_vector(i);
         @(posedge clk);
         #10;
      end
      $display("Test passed");
      $finish;
   end

endmodule

/* verilog/ctrl_ifs.sv */
`include "rv32_ctrl_defines.svh"

// decoded flags of the instruction in DX, before any kill
interface decode_if;
   import rv32_ctrl_pkg::*;

   logic dmem_en;
   logic dmem_wen;
   logic wr_reg;
   logic bra;
   logic jal;
   logic jalr;
   logic ecall;
   logic ebreak;
   logic illegal;
   logic uses_rs1;
   logic uses_rs2;
   logic [`CTRL_REG_ADDR_WIDTH-1:0] rd;
   wb_src_sel_e wb_src_sel;

   modport dec (output dmem_en, dmem_wen, wr_reg, bra, jal, jalr, ecall, ebreak, illegal,
                       uses_rs1, uses_rs2, rd, wb_src_sel);
   modport user (input dmem_en, dmem_wen, wr_reg, bra, jal, jalr, ecall, ebreak, illegal,
                       uses_rs1, uses_rs2, rd, wb_src_sel);
endinterface

// DX to WB handoff and the WB state fed back
interface stage_if;
   import rv32_ctrl_pkg::*;

   logic wr_reg_dx;
   wb_src_sel_e wb_src_sel_dx;
   logic ex_dx;
   ecode_e ex_code_dx;
   logic killed_dx;
   logic dmem_en_dx;
   logic dmem_wen_dx;
   logic [`CTRL_REG_ADDR_WIDTH-1:0] reg_to_wr_dx;
   logic stall_wb;
   logic ex_wb;
   logic wr_reg_wb;
   logic [`CTRL_REG_ADDR_WIDTH-1:0] reg_to_wr_wb;
   logic load_in_wb;

   modport dx (output wr_reg_dx, wb_src_sel_dx, ex_dx, ex_code_dx, killed_dx, dmem_en_dx,
                      dmem_wen_dx, reg_to_wr_dx,
               input  stall_wb, ex_wb);
   modport wb (input  wr_reg_dx, wb_src_sel_dx, ex_dx, ex_code_dx, killed_dx, dmem_en_dx,
                      dmem_wen_dx, reg_to_wr_dx,
               output stall_wb, ex_wb, wr_reg_wb, reg_to_wr_wb, load_in_wb);
   modport haz (input wr_reg_wb, reg_to_wr_wb, load_in_wb);
endinterface

/* verilog/dx_ctrl.sv */
module dx_ctrl (
   input  logic   clk,
   input  logic   reset,
   input  logic   ex_if,
   input  logic   kill_if,
   input  logic   misaligned_addr_p,
   input  logic   misaligned_fetch,
   input  logic   load_use,
   decode_if.user dec,
   stage_if.dx    stage,
   output logic   stall_dx,
   output logic   kill_dx,
   output logic   redirect,
   output logic   dmem_en,
   output logic   dmem_wen,
   input  logic   branch_taken
);
   import rv32_ctrl_pkg::*;

   logic had_ex_dx;       // fetch fault carried in from IF
   logic prev_killed_dx;
   logic misaligned_addr;
   logic new_ex_dx;

   always_ff @(posedge clk) begin
      if (reset) begin
         had_ex_dx <= 1'b0;
         prev_killed_dx <= 1'b1;  // reset bubble
      end else if (!stall_dx) begin
         had_ex_dx <= ex_if;
         prev_killed_dx <= kill_if;
      end
   end

   assign misaligned_addr = misaligned_addr_p && dec.dmem_en;
   assign new_ex_dx = dec.ebreak || dec.ecall || misaligned_addr || misaligned_fetch ||
                      dec.illegal;
   assign stage.ex_dx = had_ex_dx || new_ex_dx;

   // a hazard never holds an instruction that is already faulting
   assign stall_dx = stage.stall_wb || (load_use && !(stage.ex_dx || stage.ex_wb));
   assign kill_dx = stall_dx || stage.ex_dx || stage.ex_wb;
   assign stage.killed_dx = prev_killed_dx || kill_dx;

   always_comb begin
      stage.ex_code_dx = ECODE_INST_ACCESS_FAULT;
      if (had_ex_dx)
         stage.ex_code_dx = ECODE_INST_ACCESS_FAULT;
      else if (misaligned_addr)
         stage.ex_code_dx = dec.dmem_wen ? ECODE_STORE_ADDR_MISALIGNED :
                                           ECODE_LOAD_ADDR_MISALIGNED;
      else if (misaligned_fetch)
         stage.ex_code_dx = ECODE_INST_ADDR_MISALIGNED;
      else if (dec.illegal)
         stage.ex_code_dx = ECODE_ILLEGAL_INST;
      else if (dec.ebreak)
         stage.ex_code_dx = ECODE_BREAKPOINT;
      else if (dec.ecall)
         stage.ex_code_dx = ECODE_ECALL;
   end

   assign dmem_en = dec.dmem_en && !kill_dx;
   assign dmem_wen = dec.dmem_wen && !kill_dx;
   assign redirect = (branch_taken || dec.jal || dec.jalr) && !kill_dx;

   assign stage.dmem_en_dx = dmem_en;
   assign stage.dmem_wen_dx = dmem_wen;
   assign stage.wr_reg_dx = dec.wr_reg && !kill_dx;
   assign stage.wb_src_sel_dx = dec.wb_src_sel;
   assign stage.reg_to_wr_dx = dec.rd;

endmodule

/* verilog/fetch_ctrl.sv */
module fetch_ctrl (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       imem_wait,
   input  logic                       imem_badmem_e,
   input  logic                       stall_dx,
   input  logic                       ex_dx,
   input  logic                       ex_wb,
   input  logic                       redirect,
   decode_if.user                     dec,
   output logic                       stall_if,
   output logic                       kill_if,
   output logic                       ex_if,
   output rv32_ctrl_pkg::pc_src_sel_e pc_src_sel
);
   import rv32_ctrl_pkg::*;

   logic replay_if;  // refetch the same pc next cycle

   always_ff @(posedge clk) begin
      if (reset) begin
         replay_if <= 1'b1;
      end else begin
         replay_if <= !stall_dx && imem_wait && !redirect;
      end
   end

   assign stall_if = stall_dx || (imem_wait && !redirect && !ex_wb);
   assign kill_if = stall_if || ex_if || ex_dx || ex_wb || redirect || replay_if;
   assign ex_if = imem_badmem_e && !imem_wait && !redirect && !replay_if;

   always_comb begin
      if (ex_wb)
         pc_src_sel = PC_HANDLER;
      else if (replay_if || (stall_if && !imem_wait))
         pc_src_sel = PC_REPLAY;
      else if (dec.bra)
         pc_src_sel = PC_BRANCH_TARGET;  // datapath falls through when not taken
      else if (dec.jal)
         pc_src_sel = PC_JAL_TARGET;
      else if (dec.jalr)
         pc_src_sel = PC_JALR_TARGET;
      else
         pc_src_sel = PC_PLUS_FOUR;
   end

endmodule

/* verilog/hazard_unit.sv */
`include "rv32_ctrl_defines.svh"

module hazard_unit (
   input  logic [`CTRL_INST_WIDTH-1:0] inst_dx,
   decode_if.user                      dec,
   stage_if.haz                        stage,
   output logic                        bypass_rs1,
   output logic                        bypass_rs2,
   output logic                        load_use
);
   logic [`CTRL_REG_ADDR_WIDTH-1:0] rs1_addr;
   logic [`CTRL_REG_ADDR_WIDTH-1:0] rs2_addr;
   logic raw_rs1;
   logic raw_rs2;

   assign rs1_addr = inst_dx[19:15];
   assign rs2_addr = inst_dx[24:20];

   // x0 never forwards
   assign raw_rs1 = stage.wr_reg_wb && dec.uses_rs1 && (rs1_addr != '0) &&
                    (rs1_addr == stage.reg_to_wr_wb);
   assign raw_rs2 = stage.wr_reg_wb && dec.uses_rs2 && (rs2_addr != '0) &&
                    (rs2_addr == stage.reg_to_wr_wb);

   assign bypass_rs1 = raw_rs1 && !stage.load_in_wb;
   assign bypass_rs2 = raw_rs2 && !stage.load_in_wb;
   assign load_use = stage.load_in_wb && (raw_rs1 || raw_rs2);  // load data not ready yet

endmodule

/* verilog/inst_decoder.sv */
`include "rv32_ctrl_defines.svh"

module inst_decoder (
   input  logic [`CTRL_INST_WIDTH-1:0]     inst_dx,
   input  logic                            cmp_true,
   decode_if.dec                           dec,
   output rv32_ctrl_pkg::alu_op_e          alu_op,
   output rv32_ctrl_pkg::imm_type_e        imm_type,
   output rv32_ctrl_pkg::src_a_sel_e       src_a_sel,
   output rv32_ctrl_pkg::src_b_sel_e       src_b_sel,
   output logic                            branch_taken,
   output logic [2:0]                      dmem_size,
   output logic [`CTRL_MEM_TYPE_WIDTH-1:0] dmem_type
);
   import rv32_ctrl_pkg::*;

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   logic [11:0] funct12;
   logic [`CTRL_REG_ADDR_WIDTH-1:0] rs1_addr;
   logic [`CTRL_REG_ADDR_WIDTH-1:0] rd_addr;
   alu_op_e alu_op_arith;

   assign opcode = inst_dx[6:0];
   assign funct3 = inst_dx[14:12];
   assign funct7 = inst_dx[31:25];
   assign funct12 = inst_dx[31:20];
   assign rs1_addr = inst_dx[19:15];
   assign rd_addr = inst_dx[11:7];

   assign dec.rd = rd_addr;
   assign dmem_size = {1'b0, funct3[1:0]};
   assign dmem_type = funct3;  // bit 2 is the unsigned flag

   // OP and OP-IMM share the funct3 map, only OP has SUB
   always_comb begin
      case (funct3)
         FUNCT3_ADD_SUB: alu_op_arith = (opcode == OPC_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
         FUNCT3_SLL:     alu_op_arith = ALU_SLL;
         FUNCT3_SLT:     alu_op_arith = ALU_SLT;
         FUNCT3_SLTU:    alu_op_arith = ALU_SLTU;
         FUNCT3_XOR:     alu_op_arith = ALU_XOR;
         FUNCT3_SRA_SRL: alu_op_arith = funct7[5] ? ALU_SRA : ALU_SRL;
         FUNCT3_OR:      alu_op_arith = ALU_OR;
         FUNCT3_AND:     alu_op_arith = ALU_AND;
      endcase
   end

   always_comb begin
      dec.dmem_en = 1'b0;
      dec.dmem_wen = 1'b0;
      dec.wr_reg = 1'b0;
      dec.bra = 1'b0;
      dec.jal = 1'b0;
      dec.jalr = 1'b0;
      dec.ecall = 1'b0;
      dec.ebreak = 1'b0;
      dec.illegal = 1'b0;
      dec.uses_rs1 = 1'b1;
      dec.uses_rs2 = 1'b0;
      dec.wb_src_sel = WB_SRC_ALU;
      branch_taken = 1'b0;
      imm_type = IMM_I;
      src_a_sel = SRC_A_RS1;
      src_b_sel = SRC_B_IMM;
      alu_op = ALU_ADD;
      case (opcode)
         OPC_LOAD: begin
            dec.dmem_en = 1'b1;
            dec.wr_reg = 1'b1;
            dec.wb_src_sel = WB_SRC_MEM;
         end
         OPC_STORE: begin
            dec.uses_rs2 = 1'b1;
            dec.dmem_en = 1'b1;
            dec.dmem_wen = 1'b1;
            imm_type = IMM_S;
         end
         OPC_BRANCH: begin
            dec.uses_rs2 = 1'b1;
            dec.bra = 1'b1;
            branch_taken = cmp_true;
            src_b_sel = SRC_B_RS2;
            case (funct3)
               FUNCT3_BEQ:  alu_op = ALU_SEQ;
               FUNCT3_BNE:  alu_op = ALU_SNE;
               FUNCT3_BLT:  alu_op = ALU_SLT;
               FUNCT3_BGE:  alu_op = ALU_SGE;
               FUNCT3_BLTU: alu_op = ALU_SLTU;
               FUNCT3_BGEU: alu_op = ALU_SGEU;
               default:     dec.illegal = 1'b1;
            endcase
         end
         OPC_JAL: begin  // link value is pc + 4
            dec.jal = 1'b1;
            dec.wr_reg = 1'b1;
            dec.uses_rs1 = 1'b0;
            src_a_sel = SRC_A_PC;
            src_b_sel = SRC_B_FOUR;
         end
         OPC_JALR: begin
            dec.jalr = 1'b1;
            dec.wr_reg = 1'b1;
            dec.illegal = (funct3 != FUNCT3_JALR);
            src_a_sel = SRC_A_PC;
            src_b_sel = SRC_B_FOUR;
         end
         OPC_MISC_MEM: begin
            // plain fence is a no-op here, fence.i is not supported
            if (funct3 != FUNCT3_FENCE || inst_dx[31:28] != 4'd0 || rs1_addr != '0 ||
                rd_addr != '0)
               dec.illegal = 1'b1;
         end
         OPC_OP_IMM: begin
            dec.wr_reg = 1'b1;
            alu_op = alu_op_arith;
            if (inst_dx[25] && (funct3 == FUNCT3_SLL || funct3 == FUNCT3_SRA_SRL))
               dec.illegal = 1'b1;  // shamt[5] set
         end
         OPC_OP: begin
            dec.uses_rs2 = 1'b1;
            dec.wr_reg = 1'b1;
            src_b_sel = SRC_B_RS2;
            alu_op = alu_op_arith;
            if (funct7 == FUNCT7_MUL_DIV)
               dec.illegal = 1'b1;  // no M extension
         end
         OPC_SYSTEM: begin
            if (funct3 == FUNCT3_PRIV && rs1_addr == '0 && rd_addr == '0) begin
               case (funct12)
                  FUNCT12_ECALL:  dec.ecall = 1'b1;
                  FUNCT12_EBREAK: dec.ebreak = 1'b1;
                  default:        dec.illegal = 1'b1;
               endcase
            end else begin
               dec.illegal = 1'b1;  // csr ops, mret and wfi
            end
         end
         OPC_AUIPC: begin
            dec.wr_reg = 1'b1;
            dec.uses_rs1 = 1'b0;
            src_a_sel = SRC_A_PC;
            imm_type = IMM_U;
         end
         OPC_LUI: begin
            dec.wr_reg = 1'b1;
            dec.uses_rs1 = 1'b0;
            src_a_sel = SRC_A_ZERO;
            imm_type = IMM_U;
         end
         default: dec.illegal = 1'b1;
      endcase
   end

endmodule

/* verilog/rv32_ctrl.sv */
`include "rv32_ctrl_defines.svh"

module rv32_ctrl (
   input  logic                            clk,
   input  logic                            reset,
   input  logic [`CTRL_INST_WIDTH-1:0]     inst_dx,
   input  logic                            imem_wait,
   input  logic                            imem_badmem_e,
   input  logic                            dmem_wait,
   input  logic                            dmem_badmem_e,
   input  logic                            cmp_true,
   input  logic                            misaligned_addr_p,
   input  logic                            misaligned_fetch,
   output rv32_ctrl_pkg::pc_src_sel_e      pc_src_sel,
   output logic                            branch_taken,
   output rv32_ctrl_pkg::imm_type_e        imm_type,
   output logic                            bypass_rs1,
   output logic                            bypass_rs2,
   output rv32_ctrl_pkg::src_a_sel_e       src_a_sel,
   output rv32_ctrl_pkg::src_b_sel_e       src_b_sel,
   output rv32_ctrl_pkg::alu_op_e          alu_op,
   output logic                            dmem_en,
   output logic                            dmem_wen,
   output logic [2:0]                      dmem_size,
   output logic [`CTRL_MEM_TYPE_WIDTH-1:0] dmem_type,
   output logic                            wr_reg_wb,
   output logic [`CTRL_REG_ADDR_WIDTH-1:0] reg_to_wr_wb,
   output rv32_ctrl_pkg::wb_src_sel_e      wb_src_sel_wb,
   output logic                            stall_if,
   output logic                            kill_if,
   output logic                            stall_dx,
   output logic                            kill_dx,
   output logic                            stall_wb,
   output logic                            kill_wb,
   output logic                            exception_wb,
   output rv32_ctrl_pkg::ecode_e           exception_code_wb,
   output logic                            retire_wb
);
   logic ex_if;
   logic redirect;
   logic load_use;

   decode_if dec_bus ();
   stage_if stage_bus ();

   inst_decoder decoder0 (
      .inst_dx(inst_dx), .cmp_true(cmp_true), .dec(dec_bus),
      .alu_op(alu_op), .imm_type(imm_type), .src_a_sel(src_a_sel), .src_b_sel(src_b_sel),
      .branch_taken(branch_taken), .dmem_size(dmem_size), .dmem_type(dmem_type)
   );

   fetch_ctrl fetch0 (
      .clk(clk), .reset(reset), .imem_wait(imem_wait), .imem_badmem_e(imem_badmem_e),
      .stall_dx(stall_dx), .ex_dx(stage_bus.ex_dx), .ex_wb(stage_bus.ex_wb),
      .redirect(redirect), .dec(dec_bus), .stall_if(stall_if), .kill_if(kill_if),
      .ex_if(ex_if), .pc_src_sel(pc_src_sel)
   );

   dx_ctrl dx0 (
      .clk(clk), .reset(reset), .ex_if(ex_if), .kill_if(kill_if),
      .misaligned_addr_p(misaligned_addr_p), .misaligned_fetch(misaligned_fetch),
      .load_use(load_use), .dec(dec_bus), .stage(stage_bus), .stall_dx(stall_dx),
      .kill_dx(kill_dx), .redirect(redirect), .dmem_en(dmem_en), .dmem_wen(dmem_wen),
      .branch_taken(branch_taken)
   );

   wb_ctrl wb0 (
      .clk(clk), .reset(reset), .dmem_wait(dmem_wait), .dmem_badmem_e(dmem_badmem_e),
      .stage(stage_bus), .stall_wb(stall_wb), .kill_wb(kill_wb),
      .exception_wb(exception_wb), .exception_code_wb(exception_code_wb),
      .retire_wb(retire_wb), .wb_src_sel_wb(wb_src_sel_wb)
   );

   hazard_unit hazard0 (
      .inst_dx(inst_dx), .dec(dec_bus), .stage(stage_bus),
      .bypass_rs1(bypass_rs1), .bypass_rs2(bypass_rs2), .load_use(load_use)
   );

   assign wr_reg_wb = stage_bus.wr_reg_wb;
   assign reg_to_wr_wb = stage_bus.reg_to_wr_wb;

endmodule

/* verilog/rv32_ctrl_defines.svh */
`ifndef RV32_CTRL_DEFINES_SVH
`define RV32_CTRL_DEFINES_SVH

`define CTRL_INST_WIDTH 32
`define CTRL_REG_ADDR_WIDTH 5
`define CTRL_ECODE_WIDTH 4     // mcause code field
`define CTRL_ALU_OP_WIDTH 4
`define CTRL_MEM_TYPE_WIDTH 3  // funct3 of loads and stores

`endif

/* verilog/rv32_ctrl_pkg.sv */
`include "rv32_ctrl_defines.svh"

package rv32_ctrl_pkg;

   typedef enum logic [6:0] {
      OPC_LOAD     = 7'b0000011,
      OPC_STORE    = 7'b0100011,
      OPC_BRANCH   = 7'b1100011,
      OPC_JAL      = 7'b1101111,
      OPC_JALR     = 7'b1100111,
      OPC_MISC_MEM = 7'b0001111,
      OPC_OP_IMM   = 7'b0010011,
      OPC_OP       = 7'b0110011,
      OPC_SYSTEM   = 7'b1110011,
      OPC_AUIPC    = 7'b0010111,
      OPC_LUI      = 7'b0110111
   } opcode_e;

   typedef enum logic [`CTRL_ALU_OP_WIDTH-1:0] {
      ALU_ADD  = 4'd0,
      ALU_SLL  = 4'd1,
      ALU_XOR  = 4'd4,
      ALU_SRL  = 4'd5,
      ALU_OR   = 4'd6,
      ALU_AND  = 4'd7,
      ALU_SEQ  = 4'd8,
      ALU_SNE  = 4'd9,
      ALU_SUB  = 4'd10,
      ALU_SRA  = 4'd11,
      ALU_SLT  = 4'd12,
      ALU_SGE  = 4'd13,
      ALU_SLTU = 4'd14,
      ALU_SGEU = 4'd15
   } alu_op_e;

   typedef enum logic [1:0] {IMM_I, IMM_S, IMM_U} imm_type_e;
   typedef enum logic [1:0] {SRC_A_RS1, SRC_A_PC, SRC_A_ZERO} src_a_sel_e;
   typedef enum logic [1:0] {SRC_B_RS2, SRC_B_IMM, SRC_B_FOUR} src_b_sel_e;
   typedef enum logic {WB_SRC_ALU, WB_SRC_MEM} wb_src_sel_e;

   typedef enum logic [2:0] {
      PC_PLUS_FOUR,
      PC_BRANCH_TARGET,
      PC_JAL_TARGET,
      PC_JALR_TARGET,
      PC_REPLAY,
      PC_HANDLER
   } pc_src_sel_e;

   typedef enum logic [`CTRL_ECODE_WIDTH-1:0] {
      ECODE_INST_ADDR_MISALIGNED  = 4'd0,
      ECODE_INST_ACCESS_FAULT     = 4'd1,
      ECODE_ILLEGAL_INST          = 4'd2,
      ECODE_BREAKPOINT            = 4'd3,
      ECODE_LOAD_ADDR_MISALIGNED  = 4'd4,
      ECODE_LOAD_ACCESS_FAULT     = 4'd5,
      ECODE_STORE_ADDR_MISALIGNED = 4'd6,
      ECODE_STORE_ACCESS_FAULT    = 4'd7,
      ECODE_ECALL                 = 4'd11  // always m-mode
   } ecode_e;

   localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
   localparam logic [2:0] FUNCT3_SLL     = 3'b001;
   localparam logic [2:0] FUNCT3_SLT     = 3'b010;
   localparam logic [2:0] FUNCT3_SLTU    = 3'b011;
   localparam logic [2:0] FUNCT3_XOR     = 3'b100;
   localparam logic [2:0] FUNCT3_SRA_SRL = 3'b101;
   localparam logic [2:0] FUNCT3_OR      = 3'b110;
   localparam logic [2:0] FUNCT3_AND     = 3'b111;

   localparam logic [2:0] FUNCT3_BEQ  = 3'b000;
   localparam logic [2:0] FUNCT3_BNE  = 3'b001;
   localparam logic [2:0] FUNCT3_BLT  = 3'b100;
   localparam logic [2:0] FUNCT3_BGE  = 3'b101;
   localparam logic [2:0] FUNCT3_BLTU = 3'b110;
   localparam logic [2:0] FUNCT3_BGEU = 3'b111;

   localparam logic [2:0] FUNCT3_JALR  = 3'b000;
   localparam logic [2:0] FUNCT3_FENCE = 3'b000;
   localparam logic [2:0] FUNCT3_PRIV  = 3'b000;

   localparam logic [6:0] FUNCT7_MUL_DIV = 7'b0000001;
   localparam logic [11:0] FUNCT12_ECALL = 12'h000;
   localparam logic [11:0] FUNCT12_EBREAK = 12'h001;

endpackage

/* verilog/wb_ctrl.sv */
module wb_ctrl (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       dmem_wait,
   input  logic                       dmem_badmem_e,
   stage_if.wb                        stage,
   output logic                       stall_wb,
   output logic                       kill_wb,
   output logic                       exception_wb,
   output rv32_ctrl_pkg::ecode_e      exception_code_wb,
   output logic                       retire_wb,
   output rv32_ctrl_pkg::wb_src_sel_e wb_src_sel_wb
);
   import rv32_ctrl_pkg::*;

   logic wr_reg_unkilled_wb;
   logic had_ex_wb;
   ecode_e prev_ex_code_wb;
   logic store_in_wb;
   logic dmem_en_wb;
   logic prev_killed_wb;

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_reg_unkilled_wb <= 1'b0;
         had_ex_wb <= 1'b0;
         store_in_wb <= 1'b0;
         dmem_en_wb <= 1'b0;
         prev_killed_wb <= 1'b1;
      end else if (!stall_wb) begin
         wr_reg_unkilled_wb <= stage.wr_reg_dx;
         had_ex_wb <= stage.ex_dx;
         store_in_wb <= stage.dmem_wen_dx;
         dmem_en_wb <= stage.dmem_en_dx;
         prev_killed_wb <= stage.killed_dx;
      end
   end

   always_ff @(posedge clk) begin
      if (!stall_wb) begin
         prev_ex_code_wb <= stage.ex_code_dx;
         stage.reg_to_wr_wb <= stage.reg_to_wr_dx;
         wb_src_sel_wb <= stage.wb_src_sel_dx;
      end
   end

   assign exception_wb = had_ex_wb || dmem_badmem_e;
   assign stall_wb = dmem_wait && dmem_en_wb && !exception_wb;
   assign kill_wb = stall_wb || exception_wb;

   // a bus fault in WB only names the cause when DX raised none
   always_comb begin
      exception_code_wb = prev_ex_code_wb;
      if (!had_ex_wb && dmem_badmem_e)
         exception_code_wb = wr_reg_unkilled_wb ? ECODE_LOAD_ACCESS_FAULT :
                                                  ECODE_STORE_ACCESS_FAULT;
   end

   assign retire_wb = !(kill_wb || prev_killed_wb);

   assign stage.stall_wb = stall_wb;
   assign stage.ex_wb = exception_wb;
   assign stage.wr_reg_wb = wr_reg_unkilled_wb && !kill_wb;
   assign stage.load_in_wb = dmem_en_wb && !store_in_wb;

endmodule
